// File: vlog.f
+incdir+common
common/zx_bus_pkg.sv
common/zx_dram_pkg.sv
hdl/zx_pager.sv
zmem/zmem_front.sv
zmem/zmem_req_fifo.sv
zmem/zmem_wb_master.sv
hdl/zx_memsys.sv
testbench/wb_ram_model.sv
testbench/zx_memsys_sva.sv
testbench/tb_zx_memsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_zx_memsys
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: testbench/tb_zx_memsys.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module tb_zx_memsys;

	logic                 fclk;
	logic                 rst_n;
	logic [15:0]          za;
	logic [7:0]           zd_in;
	logic                 mreq_n;
	logic                 iorq_n;
	logic                 rd_n;
	logic                 wr_n;
	logic [7:0]           zd_out;
	logic                 zd_ena;
	logic                 wait_n;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [`ZX_WB_AW-1:0] wb_adr;
	logic [1:0]           wb_sel;
	logic [15:0]          wb_dat_o;
	logic [15:0]          wb_dat_i;
	logic                 wb_ack;

	integer               seed = 32'hc847_2196;
	integer               cycles = 0;
	integer               test_errs;
	integer               write_stalls = 0;
	integer               n_pass = 0;
	integer               n_fail = 0;

	// expected page map and written bytes
	logic [5:0]           map_page [4];
	logic                 map_ram  [4];
	logic [7:0]           shadow [int];

	zx_memsys dut
	(
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.zd_out(zd_out), .zd_ena(zd_ena), .wait_n(wait_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_sel(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

	wb_ram_model #(.SEED(32'hc847_2196)) ram
	(
		.fclk(fclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

	always #4 fclk = ~fclk;

	// 300 accesses of at most 30 cycles, with margin
	always @(posedge fclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= 20000)
		begin
			$display("the run timed out after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [20:0] map_addr(input logic [15:0] a);
		return {!map_ram[a[15:14]], map_page[a[15:14]], a[13:0]};
	endfunction

	function automatic logic [7:0] expect_byte(input logic [20:0] addr);
		if (shadow.exists(int'(addr)))
			return shadow[int'(addr)];
		return addr[7:0] ^ addr[15:8] ^ {3'b000, addr[20:16]};
	endfunction

	////////////////////////////////////////////////////////////////////////
	// z80 bus tasks
	////////////////////////////////////////////////////////////////////////

	// hold the strobes until wait_n is high at a rising edge
	task automatic finish_access(output logic [7:0] data, output logic waited);
		waited = 1'b0;
		@(negedge fclk);
		while (!wait_n)
		begin
			waited = 1'b1;
			@(negedge fclk);
		end
		data = zd_out;
		if (!rd_n && !zd_ena)
		begin
			$display("error %0t: read of %h returned with zd_ena low", $time, za);
			test_errs++;
		end
		@(posedge fclk);
		#1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		@(posedge fclk);
		#1;
	endtask

	task automatic mem_read(input logic [15:0] a, output logic [7:0] data);
		logic waited;
		za     = a;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		finish_access(data, waited);
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		logic [7:0] unused;
		logic       waited;
		za     = a;
		zd_in  = d;
		mreq_n = 1'b0;
		wr_n   = 1'b0;
		finish_access(unused, waited);
		if (waited)
			write_stalls++;
		// rom writes leave memory unchanged
		if (map_ram[a[15:14]])
			shadow[int'(map_addr(a))] = d;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic [7:0] unused;
		logic       waited;
		za     = a;
		zd_in  = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		finish_access(unused, waited);
		if (waited)
		begin
			$display("error %0t: i/o write to %h was held by wait_n", $time, a);
			test_errs++;
		end
	endtask

	task automatic check_read(input logic [15:0] a);
		logic [7:0] got;
		logic [7:0] exp;
		mem_read(a, got);
		exp = expect_byte(map_addr(a));
		if (got !== exp)
		begin
			$display("error %0t: read %h gave %h, expected %h", $time, a, got, exp);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
		begin
			n_pass++;
			$display("%s: pass", name);
		end
		else
		begin
			n_fail++;
			$display("%s: fail, %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////

	task automatic test_reset_map();
		check_read(16'h0123);
		check_read(16'h4567);
		check_read(16'h89AB);
		check_read(16'hCDEF);
		end_test("reset map");
	endtask

	task automatic test_7ffd();
		io_write(16'h7FFD, 8'h13);
		map_page[3] = 6'd3;
		map_page[0] = 6'd1;
		check_read(16'hC042);
		check_read(16'h0042);
		// lock bit set with this write
		io_write(16'h7FFD, 8'h24);
		map_page[3] = 6'd4;
		map_page[0] = 6'd0;
		check_read(16'hC1F0);
		io_write(16'h7FFD, 8'h17);
		check_read(16'hC1F0);
		check_read(16'h01F0);
		end_test("7ffd paging");
	endtask

	task automatic test_atm();
		logic [5:0] pg;
		io_write(16'h0077, 8'h01);
		for (int w = 0; w < 4; w++)
		begin
			pg = $random(seed);
			map_page[w] = pg;
			map_ram[w]  = (w != 0);
			io_write({w[1:0], 14'h00F7}, {map_ram[w], 1'b0, pg});
		end
		for (int i = 0; i < 16; i++)
			check_read({i[1:0], 14'($random(seed))});
		end_test("atm mode");
	endtask

	task automatic test_ordering();
		logic [13:0] offs [3];
		offs[0] = 14'h0010;
		offs[1] = 14'h0011;
		offs[2] = 14'h2200;
		io_write(16'h40F7, 8'h85);
		io_write(16'hC0F7, 8'h85);
		map_page[1] = 6'd5;
		map_ram[1]  = 1'b1;
		map_page[3] = 6'd5;
		map_ram[3]  = 1'b1;
		write_stalls = 0;
		for (int i = 0; i < 10; i++)
			mem_write({2'b01, offs[$unsigned($random(seed)) % 3]}, 8'($random(seed)));
		if (write_stalls == 0)
		begin
			$display("write ordering: no write was held back by a full queue");
			test_errs++;
		end
		for (int i = 0; i < 3; i++)
		begin
			check_read({2'b01, offs[i]});
			check_read({2'b11, offs[i]});
		end
		end_test("write ordering");
	endtask

	task automatic test_rom_protect();
		mem_write(16'h0100, ~expect_byte(map_addr(16'h0100)));
		mem_write(16'h0101, ~expect_byte(map_addr(16'h0101)));
		check_read(16'h0100);
		check_read(16'h0101);
		end_test("rom protection");
	endtask

	initial
	begin
		fclk   = 1'b0;
		rst_n  = 1'b0;
		za     = 16'h0;
		zd_in  = 8'h0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		test_errs = 0;
		map_page[0] = 6'd0;
		map_page[1] = 6'd5;
		map_page[2] = 6'd2;
		map_page[3] = 6'd0;
		map_ram[0] = 1'b0;
		map_ram[1] = 1'b1;
		map_ram[2] = 1'b1;
		map_ram[3] = 1'b1;
		repeat (2) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		@(posedge fclk);
		#1;
		test_reset_map();
		test_7ffd();
		test_atm();
		test_ordering();
		test_rom_protect();
		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: testbench/zx_memsys_sva.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zx_memsys_sva
(
	input logic                 fclk,
	input logic                 rst_n,
	input logic                 mreq_n,
	input logic                 rd_n,
	input logic                 zd_ena,
	input logic                 wait_n,
	input logic                 wb_cyc,
	input logic                 wb_stb,
	input logic                 wb_we,
	input logic [`ZX_WB_AW-1:0] wb_adr,
	input logic [1:0]           wb_sel,
	input logic [15:0]          wb_dat_o,
	input logic                 wb_ack
);

	// wishbone classic rules, one transfer per cycle
	a_ack_drop: assert property (@(posedge fclk) disable iff (!rst_n)
		wb_stb && wb_ack |=> !wb_stb && !wb_cyc)
		else $error("wb_stb or wb_cyc held after ack");

	a_req_stable: assert property (@(posedge fclk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we)
			&& $stable(wb_sel) && $stable(wb_dat_o))
		else $error("wishbone request changed before ack");

	// z80 side
	a_zd_ena: assert property (@(posedge fclk) disable iff (!rst_n)
		zd_ena |-> !mreq_n && !rd_n && wait_n)
		else $error("zd_ena outside a released memory read");

	a_wait_rst: assert property (@(posedge fclk) $rose(rst_n) |-> wait_n)
		else $error("wait_n low right after reset");

endmodule

bind zx_memsys zx_memsys_sva sva
(
	.fclk(fclk), .rst_n(rst_n), .mreq_n(mreq_n), .rd_n(rd_n),
	.zd_ena(zd_ena), .wait_n(wait_n),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
	.wb_sel(wb_sel), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
);

// File: testbench/wb_ram_model.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module wb_ram_model
#(
	parameter int SEED = 32'hc847_2196
)
(
	input  logic                 fclk,
	input  logic                 rst_n,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`ZX_WB_AW-1:0] wb_adr,
	input  logic [1:0]           wb_sel,
	input  logic [15:0]          wb_dat_o,
	output logic [15:0]          wb_dat_i,
	output logic                 wb_ack
);

	logic [15:0] mem [1 << `ZX_WB_AW];
	integer      seed;
	integer      delay;
	integer      wait_left;
	logic        busy;
	logic [20:0] lo_addr;
	logic [20:0] hi_addr;

	// byte at A holds A[7:0] ^ A[15:8] ^ A[20:16]
	initial
	begin
		seed = SEED;
		for (int w = 0; w < (1 << `ZX_WB_AW); w++)
		begin
			lo_addr = {w[19:0], 1'b0};
			hi_addr = {w[19:0], 1'b1};
			mem[w] = {hi_addr[7:0] ^ hi_addr[15:8] ^ {3'b000, hi_addr[20:16]},
				lo_addr[7:0] ^ lo_addr[15:8] ^ {3'b000, lo_addr[20:16]}};
		end
	end

	always @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_ack   <= 1'b0;
			busy     <= 1'b0;
			delay    <= 0;
			wb_dat_i <= 16'h0;
		end
		else if (wb_ack)
		begin
			wb_ack <= 1'b0;
			busy   <= 1'b0;
		end
		else if (wb_cyc && wb_stb)
		begin
			// a new request draws 0 to 3 wait cycles
			if (busy)
				wait_left = delay;
			else
				wait_left = $random(seed) & 3;
			if (wait_left == 0)
			begin
				wb_ack <= 1'b1;
				if (wb_we)
				begin
					if (wb_sel[0])
						mem[wb_adr][7:0] <= wb_dat_o[7:0];
					if (wb_sel[1])
						mem[wb_adr][15:8] <= wb_dat_o[15:8];
				end
				wb_dat_i <= mem[wb_adr];
			end
			else
			begin
				busy  <= 1'b1;
				delay <= wait_left - 1;
			end
		end
	end

endmodule

// File: hdl/zx_memsys.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zx_memsys
(
	input  logic                 fclk,
	input  logic                 rst_n,

	// z80 bus
	input  logic [15:0]          za,
	input  logic [7:0]           zd_in,
	input  logic                 mreq_n,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	output logic [7:0]           zd_out,
	output logic                 zd_ena,
	output logic                 wait_n,

	// wishbone memory side
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic                 wb_we,
	output logic [`ZX_WB_AW-1:0] wb_adr,
	output logic [1:0]           wb_sel,
	output logic [15:0]          wb_dat_o,
	input  logic [15:0]          wb_dat_i,
	input  logic                 wb_ack
);

	logic [`ZX_PAGE_W-1:0]   win0_page;
	logic [`ZX_PAGE_W-1:0]   win1_page;
	logic [`ZX_PAGE_W-1:0]   win2_page;
	logic [`ZX_PAGE_W-1:0]   win3_page;
	logic [3:0]              win_ram;

	logic                    push;
	logic                    push_rnw;
	zx_dram_pkg::dram_addr_t push_addr;
	logic [7:0]              push_data;
	logic                    full;

	logic                    pop;
	logic                    empty;
	logic                    head_rnw;
	zx_dram_pkg::dram_addr_t head_addr;
	logic [7:0]              head_data;

	logic                    rd_valid;
	logic [7:0]              rd_byte;

	zx_pager pager
	(
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in),
		.iorq_n(iorq_n), .wr_n(wr_n),
		.win0_page(win0_page), .win1_page(win1_page),
		.win2_page(win2_page), .win3_page(win3_page), .win_ram(win_ram)
	);

	zmem_front front
	(
		.fclk(fclk), .rst_n(rst_n), .za(za), .zd_in(zd_in),
		.mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.win0_page(win0_page), .win1_page(win1_page),
		.win2_page(win2_page), .win3_page(win3_page), .win_ram(win_ram),
		.full(full), .rd_valid(rd_valid), .rd_byte(rd_byte),
		.zd_out(zd_out), .zd_ena(zd_ena), .wait_n(wait_n),
		.push(push), .push_rnw(push_rnw), .push_addr(push_addr), .push_data(push_data)
	);

	zmem_req_fifo #(.DEPTH(`ZX_FIFO_DEPTH)) req_fifo
	(
		.fclk(fclk), .rst_n(rst_n),
		.push(push), .push_rnw(push_rnw), .push_addr(push_addr), .push_data(push_data),
		.pop(pop), .full(full), .empty(empty),
		.head_rnw(head_rnw), .head_addr(head_addr), .head_data(head_data)
	);

	zmem_wb_master wb_master
	(
		.fclk(fclk), .rst_n(rst_n), .empty(empty),
		.head_rnw(head_rnw), .head_addr(head_addr), .head_data(head_data),
		.wb_ack(wb_ack), .wb_dat_i(wb_dat_i), .pop(pop),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_sel(wb_sel), .wb_dat_o(wb_dat_o),
		.rd_valid(rd_valid), .rd_byte(rd_byte)
	);

endmodule

// File: zmem/zmem_wb_master.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zmem_wb_master
(
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic                    empty,
	input  logic                    head_rnw,
	input  zx_dram_pkg::dram_addr_t head_addr,
	input  logic [7:0]              head_data,
	input  logic                    wb_ack,
	input  logic [15:0]             wb_dat_i,
	output logic                    pop,
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`ZX_WB_AW-1:0]    wb_adr,
	output logic [1:0]              wb_sel,
	output logic [15:0]             wb_dat_o,
	output logic                    rd_valid,
	output logic [7:0]              rd_byte
);

	zx_dram_pkg::wb_state_e  state;
	zx_dram_pkg::dram_addr_t req_addr;
	logic                    req_we;
	logic [7:0]              req_data;

	// head is taken whenever the bus is free
	assign pop = (state == zx_dram_pkg::WB_IDLE) && !empty;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= zx_dram_pkg::WB_IDLE;
			req_we <= 1'b0;
		end
		else
		begin
			case (state)
				zx_dram_pkg::WB_IDLE:
				begin
					if (!empty)
					begin
						state  <= zx_dram_pkg::WB_BUS;
						req_we <= !head_rnw;
					end
				end
				zx_dram_pkg::WB_BUS:
				begin
					if (wb_ack)
						state <= req_we ? zx_dram_pkg::WB_IDLE : zx_dram_pkg::WB_RESPOND;
				end
				default:
					state <= zx_dram_pkg::WB_IDLE;
			endcase
		end
	end

	// request payload and returned byte
	always_ff @(posedge fclk)
	begin
		if (pop)
		begin
			req_addr <= head_addr;
			req_data <= head_data;
		end
		if (state == zx_dram_pkg::WB_BUS && wb_ack)
			rd_byte <= req_addr[0] ? wb_dat_i[15:8] : wb_dat_i[7:0];
	end

	assign wb_cyc   = (state == zx_dram_pkg::WB_BUS);
	assign wb_stb   = (state == zx_dram_pkg::WB_BUS);
	assign wb_we    = req_we;
	assign wb_adr   = req_addr[`ZX_DRAM_AW-1:1];
	// odd bytes on the upper lane
	assign wb_sel   = req_addr[0] ? 2'b10 : 2'b01;
	assign wb_dat_o = {req_data, req_data};
	assign rd_valid = (state == zx_dram_pkg::WB_RESPOND);

endmodule

// File: zmem/zmem_req_fifo.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zmem_req_fifo
#(
	parameter int DEPTH = `ZX_FIFO_DEPTH
)
(
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic                    push,
	input  logic                    push_rnw,
	input  zx_dram_pkg::dram_addr_t push_addr,
	input  logic [7:0]              push_data,
	input  logic                    pop,
	output logic                    full,
	output logic                    empty,
	output logic                    head_rnw,
	output zx_dram_pkg::dram_addr_t head_addr,
	output logic [7:0]              head_data
);

	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	logic                    mem_rnw  [DEPTH];
	zx_dram_pkg::dram_addr_t mem_addr [DEPTH];
	logic [7:0]              mem_data [DEPTH];
	logic [PW-1:0]           wr_ptr;
	logic [PW-1:0]           rd_ptr;
	logic [CW-1:0]           count;
	logic                    do_push;
	logic                    do_pop;

	assign full    = (count == CW'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge fclk)
	begin
		if (do_push)
		begin
			mem_rnw[wr_ptr]  <= push_rnw;
			mem_addr[wr_ptr] <= push_addr;
			mem_data[wr_ptr] <= push_data;
		end
	end

	assign head_rnw  = mem_rnw[rd_ptr];
	assign head_addr = mem_addr[rd_ptr];
	assign head_data = mem_data[rd_ptr];

endmodule

// File: zmem/zmem_front.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zmem_front
(
	input  logic                   fclk,
	input  logic                   rst_n,
	input  logic [15:0]            za,
	input  logic [7:0]             zd_in,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [`ZX_PAGE_W-1:0]  win0_page,
	input  logic [`ZX_PAGE_W-1:0]  win1_page,
	input  logic [`ZX_PAGE_W-1:0]  win2_page,
	input  logic [`ZX_PAGE_W-1:0]  win3_page,
	input  logic [3:0]             win_ram,
	input  logic                   full,
	input  logic                   rd_valid,
	input  logic [7:0]             rd_byte,
	output logic [7:0]             zd_out,
	output logic                   zd_ena,
	output logic                   wait_n,
	output logic                   push,
	output logic                   push_rnw,
	output zx_dram_pkg::dram_addr_t push_addr,
	output logic [7:0]             push_data
);

	zx_bus_pkg::z_acc_e    acc;
	logic                  mem_act;
	logic                  mem_act_d;
	logic                  start;
	logic                  req_now;
	logic                  drop;
	logic                  stall_push;
	logic                  push_pend;
	logic                  rd_wait;
	logic                  rd_done;
	logic [7:0]            rd_data;
	logic [`ZX_PAGE_W-1:0] page;

	//////////////////////////////////////////////////////////////////////
	// access detection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		acc = zx_bus_pkg::ACC_NONE;
		if (!mreq_n && !rd_n)
			acc = zx_bus_pkg::ACC_MEM_RD;
		else if (!mreq_n && !wr_n)
			acc = zx_bus_pkg::ACC_MEM_WR;
	end

	assign mem_act = (acc != zx_bus_pkg::ACC_NONE);
	assign start   = mem_act && !mem_act_d;

	// window select by the top two address bits
	always_comb
	begin
		case (za[15:14])
			2'd0:    page = win0_page;
			2'd1:    page = win1_page;
			2'd2:    page = win2_page;
			default: page = win3_page;
		endcase
	end

	assign push_addr = {!win_ram[za[15:14]], page, za[13:0]};
	assign push_rnw  = (acc == zx_bus_pkg::ACC_MEM_RD);
	assign push_data = zd_in;

	//////////////////////////////////////////////////////////////////////
	// push and wait
	//////////////////////////////////////////////////////////////////////

	assign req_now    = start || push_pend;
	// writes into rom complete without a request
	assign drop       = (acc == zx_bus_pkg::ACC_MEM_WR) && !win_ram[za[15:14]];
	assign push       = req_now && !drop && !full;
	assign stall_push = req_now && !drop && full;

	assign wait_n = !(stall_push || (push && push_rnw) || rd_wait);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_act_d <= 1'b0;
			push_pend <= 1'b0;
			rd_wait   <= 1'b0;
			rd_done   <= 1'b0;
		end
		else
		begin
			mem_act_d <= mem_act;
			push_pend <= stall_push;
			if (rd_valid)
				rd_wait <= 1'b0;
			else if (push && push_rnw)
				rd_wait <= 1'b1;
			// byte stays on the bus until the strobes rise
			if (rd_valid)
				rd_done <= 1'b1;
			else if (!mem_act)
				rd_done <= 1'b0;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rd_valid)
			rd_data <= rd_byte;
	end

	assign zd_out = rd_data;
	assign zd_ena = rd_done && !mreq_n && !rd_n;

endmodule

// File: hdl/zx_pager.sv
`timescale 1ns/1ps
`include "zx_mem_cfg.svh"

module zx_pager
(
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic [15:0]           za,
	input  logic [7:0]            zd_in,
	input  logic                  iorq_n,
	input  logic                  wr_n,
	output logic [`ZX_PAGE_W-1:0] win0_page,
	output logic [`ZX_PAGE_W-1:0] win1_page,
	output logic [`ZX_PAGE_W-1:0] win2_page,
	output logic [`ZX_PAGE_W-1:0] win3_page,
	output logic [3:0]            win_ram
);

	logic                  io_wr;
	logic                  io_wr_d;
	zx_bus_pkg::z_acc_e    acc;
	zx_bus_pkg::port_op_e  port_op;

	// pentagon #7FFD state
	logic [2:0]            pent_ram;
	logic                  pent_rom;
	logic                  pent_lock;

	// atm per-window registers
	logic                  atm_en;
	logic [`ZX_PAGE_W-1:0] atm_page [4];
	logic [3:0]            atm_ram;

	assign io_wr = !iorq_n && !wr_n;
	assign acc   = (io_wr && !io_wr_d) ? zx_bus_pkg::ACC_IO_WR : zx_bus_pkg::ACC_NONE;

	always_comb
	begin
		port_op = zx_bus_pkg::PORT_NONE;
		if (acc == zx_bus_pkg::ACC_IO_WR)
		begin
			if (za[7:0] == `ZX_PORT_ATM_PAGE)
				port_op = zx_bus_pkg::PORT_ATM_PAGE;
			else if (za[7:0] == `ZX_PORT_ATM_CTRL)
				port_op = zx_bus_pkg::PORT_ATM_CTRL;
			// partial decode, A15 and A1 low
			else if (!za[15] && !za[1])
				port_op = zx_bus_pkg::PORT_7FFD;
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_d     <= 1'b0;
			pent_ram    <= 3'd0;
			pent_rom    <= 1'b0;
			pent_lock   <= 1'b0;
			atm_en      <= 1'b0;
			atm_page[0] <= '0;
			atm_page[1] <= `ZX_RST_PAGE_W1;
			atm_page[2] <= `ZX_RST_PAGE_W2;
			atm_page[3] <= '0;
			atm_ram     <= 4'b1110;
		end
		else
		begin
			io_wr_d <= io_wr;
			case (port_op)
				zx_bus_pkg::PORT_7FFD:
				begin
					// lock holds until reset
					if (!pent_lock)
					begin
						pent_ram  <= zd_in[2:0];
						pent_rom  <= zd_in[4];
						pent_lock <= zd_in[5];
					end
				end
				zx_bus_pkg::PORT_ATM_CTRL:
					atm_en <= zd_in[0];
				zx_bus_pkg::PORT_ATM_PAGE:
				begin
					atm_page[za[15:14]] <= zd_in[`ZX_PAGE_W-1:0];
					atm_ram[za[15:14]]  <= zd_in[7];
				end
				default:
				begin
				end
			endcase
		end
	end

	always_comb
	begin
		if (atm_en)
		begin
			win0_page = atm_page[0];
			win1_page = atm_page[1];
			win2_page = atm_page[2];
			win3_page = atm_page[3];
			win_ram   = atm_ram;
		end
		else
		begin
			win0_page = {{(`ZX_PAGE_W-1){1'b0}}, pent_rom};
			win1_page = `ZX_RST_PAGE_W1;
			win2_page = `ZX_RST_PAGE_W2;
			win3_page = {{(`ZX_PAGE_W-3){1'b0}}, pent_ram};
			win_ram   = 4'b1110;
		end
	end

endmodule

// File: common/zx_dram_pkg.sv
`include "zx_mem_cfg.svh"

package zx_dram_pkg;

	// byte address into the external memory
	typedef logic [`ZX_DRAM_AW-1:0] dram_addr_t;

	// wishbone master sequence
	typedef enum logic [1:0]
	{
		WB_IDLE    = 2'd0,
		WB_BUS     = 2'd1,
		WB_RESPOND = 2'd2
	} wb_state_e;

endpackage

// File: common/zx_bus_pkg.sv
package zx_bus_pkg;

	// access seen on the z80 strobes
	typedef enum logic [1:0]
	{
		ACC_NONE   = 2'd0,
		ACC_MEM_RD = 2'd1,
		ACC_MEM_WR = 2'd2,
		ACC_IO_WR  = 2'd3
	} z_acc_e;

	// decoded paging port write
	typedef enum logic [1:0]
	{
		PORT_NONE     = 2'd0,
		PORT_7FFD     = 2'd1,
		PORT_ATM_PAGE = 2'd2,
		PORT_ATM_CTRL = 2'd3
	} port_op_e;

endpackage

// File: common/zx_mem_cfg.svh
`ifndef ZX_MEM_CFG_SVH
`define ZX_MEM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// bit 20 rom, bits 19:14 page, bits 13:0 offset
`define ZX_DRAM_AW 21

// 16-bit words on the memory side
`define ZX_WB_AW 20

`define ZX_PAGE_W 6

//////////////////////////////////////////////////////////////////////
// port codes, low address byte
//////////////////////////////////////////////////////////////////////

`define ZX_PORT_ATM_PAGE 8'hF7
`define ZX_PORT_ATM_CTRL 8'h77

// posted request queue
`define ZX_FIFO_DEPTH 4

// reset map: w0 rom 0, w1 ram 5, w2 ram 2, w3 ram 0
`define ZX_RST_PAGE_W1 6'd5
`define ZX_RST_PAGE_W2 6'd2

`endif
